// File: common/trail_pkg.sv
/* shared sizes and types for the light-cycle trail map
   the map is a fixed 64x64 grid holding one tile code per cell */
package trail_pkg;

	// grid geometry
	localparam int GRID_BITS = 6;
	localparam int CELL_BITS = 2 * GRID_BITS;
	localparam int GRID_CELLS = 4096;

	// event queue
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

	typedef logic [GRID_BITS-1:0] coord_t;

	// x in the upper half, so the flat cell index is {x, y}
	typedef struct packed {
		coord_t x;
		coord_t y;
	} cell_t;

	typedef enum logic {
		PLAYER_BLUE = 1'b0,
		PLAYER_RED  = 1'b1
	} player_e;

	// up and down share the upper bit
	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_RIGHT = 2'd3
	} dir_e;

	// tile codes as stored in the map
	typedef enum logic [2:0] {
		TILE_EMPTY   = 3'd0,
		TILE_B_HORIZ = 3'd1,
		TILE_B_VERT  = 3'd2,
		TILE_R_HORIZ = 3'd3,
		TILE_R_VERT  = 3'd4,
		TILE_CORNER  = 3'd5
	} tile_e;

	typedef enum logic [1:0] {
		GS_IDLE  = 2'd0,
		GS_START = 2'd1,
		GS_PLAY  = 2'd2,
		GS_OVER  = 2'd3
	} game_state_e;

	// one cycle as seen by the game logic
	typedef struct packed {
		cell_t pos;
		dir_e  dir;
	} cycle_pos_t;

	// trail is the cell just left, head the cell just entered
	typedef struct packed {
		player_e player;
		tile_e   tile;
		cell_t   trail;
		cell_t   head;
	} trail_event_t;

	typedef struct packed {
		player_e player;
		cell_t   head;
	} collision_t;

endpackage

// File: trail_writer/tile_map.sv
`timescale 1ns/1ps
/* 4096-cell tile memory, cell index is {x, y}
   port A reads the old value when writing, both ports have one cycle of read latency */
module tile_map (
	input  logic             Clk,
	input  trail_pkg::cell_t a_cell,
	input  logic             a_we,
	input  trail_pkg::tile_e a_wtile,
	output trail_pkg::tile_e a_rtile,
	input  trail_pkg::cell_t b_cell,
	output trail_pkg::tile_e b_rtile
);

	trail_pkg::tile_e mem [trail_pkg::GRID_CELLS];
	logic [trail_pkg::CELL_BITS-1:0] a_addr;
	logic [trail_pkg::CELL_BITS-1:0] b_addr;

	assign a_addr = a_cell;
	assign b_addr = b_cell;

	// game side
	always_ff @(posedge Clk)
	begin
		a_rtile <= mem[a_addr];
		if (a_we)
			mem[a_addr] <= a_wtile;
	end

	// renderer side, read only
	always_ff @(posedge Clk)
	begin
		b_rtile <= mem[b_addr];
	end

endmodule

// File: src/trail_detect.sv
`timescale 1ns/1ps
/* compares both cycles with the last frame and issues trail events, blue first
   a frame tick that arrives while an event is still in flight is ignored */
module trail_detect (
	input  logic                    Clk,
	input  logic                    reset,
	input  logic                    frame_tick,
	input  trail_pkg::game_state_e  game_state,
	input  trail_pkg::cycle_pos_t   blue,
	input  trail_pkg::cycle_pos_t   red,
	output trail_pkg::trail_event_t ev,
	output logic                    ev_req,
	input  logic                    ev_ack
);

	typedef enum logic [1:0] {
		DET_IDLE,
		DET_BLUE,
		DET_RED,
		DET_WAIT_LOW
	} det_state_e;

	det_state_e state;
	trail_pkg::cycle_pos_t blue_old;
	trail_pkg::cycle_pos_t red_old;
	trail_pkg::trail_event_t ev_blue;
	trail_pkg::trail_event_t ev_red;
	logic red_pend;
	logic blue_moved;
	logic red_moved;
	logic accept;

	// corner beats straight, then vertical or horizontal by heading
	function automatic trail_pkg::tile_e classify(input trail_pkg::player_e p,
		input trail_pkg::dir_e d, input trail_pkg::dir_e d_old);
		trail_pkg::tile_e t;
		if (d != d_old)
			t = trail_pkg::TILE_CORNER;
		else if (d == trail_pkg::DIR_UP || d == trail_pkg::DIR_DOWN)
			t = (p == trail_pkg::PLAYER_BLUE) ? trail_pkg::TILE_B_VERT : trail_pkg::TILE_R_VERT;
		else
			t = (p == trail_pkg::PLAYER_BLUE) ? trail_pkg::TILE_B_HORIZ : trail_pkg::TILE_R_HORIZ;
		return t;
	endfunction

	assign blue_moved = (blue.pos != blue_old.pos);
	assign red_moved = (red.pos != red_old.pos);
	assign accept = frame_tick && (state == DET_IDLE);

	// snapshot on every accepted tick, events built from the old snapshot
	always_ff @(posedge Clk)
	begin
		if (accept)
		begin
			blue_old <= blue;
			red_old <= red;
			ev_blue.player <= trail_pkg::PLAYER_BLUE;
			ev_blue.tile <= classify(trail_pkg::PLAYER_BLUE, blue.dir, blue_old.dir);
			ev_blue.trail <= blue_old.pos;
			ev_blue.head <= blue.pos;
			ev_red.player <= trail_pkg::PLAYER_RED;
			ev_red.tile <= classify(trail_pkg::PLAYER_RED, red.dir, red_old.dir);
			ev_red.trail <= red_old.pos;
			ev_red.head <= red.pos;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state <= DET_IDLE;
			red_pend <= 1'b0;
		end
		else
		begin
			case (state)
				DET_IDLE:
					// events only go out during play
					if (accept && game_state == trail_pkg::GS_PLAY)
					begin
						red_pend <= blue_moved && red_moved;
						if (blue_moved)
							state <= DET_BLUE;
						else if (red_moved)
							state <= DET_RED;
					end
				DET_BLUE, DET_RED:
					if (ev_ack)
						state <= DET_WAIT_LOW;
				DET_WAIT_LOW:
					if (!ev_ack)
					begin
						red_pend <= 1'b0;
						state <= red_pend ? DET_RED : DET_IDLE;
					end
				default:
					state <= DET_IDLE;
			endcase
		end
	end

	assign ev_req = (state == DET_BLUE) || (state == DET_RED);
	assign ev = (state == DET_RED) ? ev_red : ev_blue;

	// data must hold until the receiver has taken it
	ev_stable: assert property (@(posedge Clk) disable iff (reset)
		(ev_req && !ev_ack) |=> (ev_req && $stable(ev)));

endmodule

// File: src/trail_fifo.sv
`timescale 1ns/1ps
/* four-entry event queue with four-phase req/ack on both sides
   an entry reaches the output two cycles after its input ack at the earliest */
module trail_fifo (
	input  logic                    Clk,
	input  logic                    reset,
	input  trail_pkg::trail_event_t in_ev,
	input  logic                    in_req,
	output logic                    in_ack,
	output trail_pkg::trail_event_t out_ev,
	output logic                    out_req,
	input  logic                    out_ack
);

	trail_pkg::trail_event_t mem [trail_pkg::FIFO_DEPTH];
	logic [trail_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
	logic [trail_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
	logic [trail_pkg::FIFO_PTR_BITS:0] count;
	logic avail;
	logic out_wait;
	logic push;
	logic pop;

	// a full queue simply withholds ack
	assign push = in_req && !in_ack && (count != trail_pkg::FIFO_DEPTH);
	assign pop = out_req && out_ack;

	always_ff @(posedge Clk)
	begin
		if (push)
			mem[wr_ptr] <= in_ev;
	end

	// input phase, ack follows req down before the next push
	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			in_ack <= 1'b0;
			wr_ptr <= '0;
		end
		else if (push)
		begin
			in_ack <= 1'b1;
			wr_ptr <= wr_ptr + 1'b1;
		end
		else if (in_ack && !in_req)
			in_ack <= 1'b0;
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
			count <= '0;
		else if (push && !pop)
			count <= count + 1'b1;
		else if (pop && !push)
			count <= count - 1'b1;
	end

	// output phase, launched from a registered not-empty flag
	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			avail <= 1'b0;
			out_req <= 1'b0;
			out_wait <= 1'b0;
			rd_ptr <= '0;
		end
		else
		begin
			avail <= (count != 0);
			if (pop)
			begin
				out_req <= 1'b0;
				out_wait <= 1'b1;
				rd_ptr <= rd_ptr + 1'b1;
			end
			else if (out_wait)
			begin
				if (!out_ack)
					out_wait <= 1'b0;
			end
			else if (!out_req && avail)
				out_req <= 1'b1;
		end
	end

	assign out_ev = mem[rd_ptr];

	no_overflow: assert property (@(posedge Clk) disable iff (reset)
		count <= trail_pkg::FIFO_DEPTH);
	// the lagging not-empty flag must never launch a stale entry
	no_underflow: assert property (@(posedge Clk) disable iff (reset)
		pop |-> (count != 0));

endmodule

// File: trail_writer/trail_writer.sv
`timescale 1ns/1ps
/* applies trail events to the tile map and reports head collisions
   entering GS_START sweeps all 4096 cells, events wait until the sweep ends */
module trail_writer (
	input  logic                    Clk,
	input  logic                    reset,
	input  trail_pkg::game_state_e  game_state,
	input  trail_pkg::trail_event_t ev,
	input  logic                    ev_req,
	output logic                    ev_ack,
	input  trail_pkg::cell_t        host_cell,
	output trail_pkg::tile_e        host_tile,
	output trail_pkg::collision_t   collision,
	output logic                    collision_valid,
	output logic                    clearing
);

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_CLEAR,
		WR_LOOKUP,
		WR_STORE,
		WR_ACK_LOW
	} wr_state_e;

	wr_state_e state;
	trail_pkg::game_state_e gs_prev;
	trail_pkg::trail_event_t cur;
	logic [trail_pkg::CELL_BITS-1:0] clr_cnt;
	logic clr_pend;
	logic start_edge;
	logic clr_last;

	trail_pkg::cell_t a_cell;
	logic a_we;
	trail_pkg::tile_e a_wtile;
	trail_pkg::tile_e a_rtile;

	assign start_edge = (game_state == trail_pkg::GS_START) && (gs_prev != trail_pkg::GS_START);
	assign clr_last = (clr_cnt == trail_pkg::CELL_BITS'(trail_pkg::GRID_CELLS - 1));

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state <= WR_IDLE;
			ev_ack <= 1'b0;
			clr_pend <= 1'b0;
			gs_prev <= trail_pkg::GS_IDLE;
		end
		else
		begin
			gs_prev <= game_state;
			// a start seen mid-event is held until the event finishes
			if (start_edge)
				clr_pend <= 1'b1;
			case (state)
				WR_IDLE:
					if (clr_pend || start_edge)
					begin
						clr_pend <= 1'b0;
						state <= WR_CLEAR;
					end
					else if (ev_req)
					begin
						ev_ack <= 1'b1;
						state <= WR_LOOKUP;
					end
				WR_CLEAR:
					if (clr_last)
						state <= WR_IDLE;
				WR_LOOKUP:
					state <= WR_STORE;
				WR_STORE:
					state <= WR_ACK_LOW;
				WR_ACK_LOW:
					if (!ev_req)
					begin
						ev_ack <= 1'b0;
						state <= WR_IDLE;
					end
				default:
					state <= WR_IDLE;
			endcase
		end
	end

	// event copy and sweep counter
	always_ff @(posedge Clk)
	begin
		if (state == WR_IDLE && ev_req)
			cur <= ev;
		if (state == WR_IDLE)
			clr_cnt <= '0;
		else if (state == WR_CLEAR)
			clr_cnt <= clr_cnt + 1'b1;
	end

	// port A: sweep write, head read, then trail write
	always_comb
	begin
		a_cell = cur.head;
		a_we = 1'b0;
		a_wtile = cur.tile;
		case (state)
			WR_CLEAR:
			begin
				a_cell = trail_pkg::cell_t'(clr_cnt);
				a_we = 1'b1;
				a_wtile = trail_pkg::TILE_EMPTY;
			end
			WR_STORE:
			begin
				a_cell = cur.trail;
				a_we = 1'b1;
			end
			default:
				a_we = 1'b0;
		endcase
	end

	// head tile from the lookup is valid during WR_STORE
	assign collision_valid = (state == WR_STORE) && (a_rtile != trail_pkg::TILE_EMPTY);
	assign collision = '{player: cur.player, head: cur.head};
	assign clearing = (state == WR_CLEAR);

	tile_map tile_map_inst (
		.Clk     (Clk),
		.a_cell  (a_cell),
		.a_we    (a_we),
		.a_wtile (a_wtile),
		.a_rtile (a_rtile),
		.b_cell  (host_cell),
		.b_rtile (host_tile)
	);

	// the sweep holds off both reports and the queue ack
	no_hit_in_clear: assert property (@(posedge Clk) disable iff (reset)
		clearing |-> (!collision_valid && !ev_ack));

endmodule

// File: src/trail_grid_top.sv
`timescale 1ns/1ps
/* light-cycle trail map: detector, event queue and map writer
   game_state and cycle positions come from the game logic, host port is read only */
module trail_grid_top (
	input  logic                   Clk,
	input  logic                   reset,
	input  logic                   frame_tick,
	input  trail_pkg::game_state_e game_state,
	input  trail_pkg::cycle_pos_t  blue,
	input  trail_pkg::cycle_pos_t  red,
	input  trail_pkg::cell_t       host_cell,
	output trail_pkg::tile_e       host_tile,
	output trail_pkg::collision_t  collision,
	output logic                   collision_valid,
	output logic                   clearing
);

	// detector to queue
	trail_pkg::trail_event_t det_ev;
	logic det_req;
	logic det_ack;

	// queue to writer
	trail_pkg::trail_event_t wr_ev;
	logic wr_req;
	logic wr_ack;

	trail_detect trail_detect_inst (
		.Clk        (Clk),
		.reset      (reset),
		.frame_tick (frame_tick),
		.game_state (game_state),
		.blue       (blue),
		.red        (red),
		.ev         (det_ev),
		.ev_req     (det_req),
		.ev_ack     (det_ack)
	);

	trail_fifo trail_fifo_inst (
		.Clk     (Clk),
		.reset   (reset),
		.in_ev   (det_ev),
		.in_req  (det_req),
		.in_ack  (det_ack),
		.out_ev  (wr_ev),
		.out_req (wr_req),
		.out_ack (wr_ack)
	);

	trail_writer trail_writer_inst (
		.Clk             (Clk),
		.reset           (reset),
		.game_state      (game_state),
		.ev              (wr_ev),
		.ev_req          (wr_req),
		.ev_ack          (wr_ack),
		.host_cell       (host_cell),
		.host_tile       (host_tile),
		.collision       (collision),
		.collision_valid (collision_valid),
		.clearing        (clearing)
	);

endmodule

// File: tb/tb_trail_grid.sv
`timescale 1ns/1ps
/* self-checking testbench for trail_grid_top, map and collisions checked against a model
   a tick only counts when the detector link is idle, so dropped ticks are tracked */
module tb_trail_grid;

	localparam int N_CLEARS = 3;
	localparam int N_TICKS = 37;
	localparam int LIMIT = N_CLEARS * 5000 + N_TICKS * 60 + 2000;

	logic Clk;
	logic reset;
	logic frame_tick;
	trail_pkg::game_state_e game_state;
	trail_pkg::cycle_pos_t blue;
	trail_pkg::cycle_pos_t red;
	trail_pkg::cell_t host_cell;
	trail_pkg::tile_e host_tile;
	trail_pkg::collision_t collision;
	logic collision_valid;
	logic clearing;

	// reference model
	trail_pkg::tile_e model_map [trail_pkg::GRID_CELLS];
	trail_pkg::cycle_pos_t blue_sv;
	trail_pkg::cycle_pos_t red_sv;
	trail_pkg::collision_t exp_q [$];
	trail_pkg::collision_t got_q [$];
	trail_pkg::cell_t touched_q [$];

	integer seed;
	int cycles;
	int errors;
	int checks;
	int test_errs;
	int pending;
	int ev_total;
	int wr_done;
	logic det_free;
	logic det_ack_prev;
	logic wr_ack_prev;

	trail_grid_top trail_grid_top_inst (
		.Clk             (Clk),
		.reset           (reset),
		.frame_tick      (frame_tick),
		.game_state      (game_state),
		.blue            (blue),
		.red             (red),
		.host_cell       (host_cell),
		.host_tile       (host_tile),
		.collision       (collision),
		.collision_valid (collision_valid),
		.clearing        (clearing)
	);

	initial
	begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	initial
	begin
		cycles = 0;
		while (cycles < LIMIT)
		begin
			@(posedge Clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", LIMIT);
		$display("=== FAIL ===");
		$finish;
	end

	// every collision report, in order
	always @(posedge Clk)
	begin
		if (!reset && collision_valid)
			got_q.push_back(collision);
	end

	function automatic trail_pkg::cell_t cell_at(int x, int y);
		trail_pkg::cell_t c;
		c.x = trail_pkg::coord_t'(x);
		c.y = trail_pkg::coord_t'(y);
		return c;
	endfunction

	function automatic trail_pkg::cycle_pos_t pos_at(int x, int y, trail_pkg::dir_e d);
		trail_pkg::cycle_pos_t p;
		p.pos = cell_at(x, y);
		p.dir = d;
		return p;
	endfunction

	// up lowers y, right raises x, edges wrap
	function automatic trail_pkg::cycle_pos_t advance(trail_pkg::cycle_pos_t p);
		trail_pkg::cycle_pos_t q;
		q = p;
		case (p.dir)
			trail_pkg::DIR_UP:
				q.pos.y = p.pos.y - 1'b1;
			trail_pkg::DIR_DOWN:
				q.pos.y = p.pos.y + 1'b1;
			trail_pkg::DIR_LEFT:
				q.pos.x = p.pos.x - 1'b1;
			default:
				q.pos.x = p.pos.x + 1'b1;
		endcase
		return q;
	endfunction

	// turn one time in four, stand still one time in four
	function automatic trail_pkg::cycle_pos_t random_move(trail_pkg::cycle_pos_t p);
		logic [31:0] r;
		trail_pkg::cycle_pos_t q;
		r = $random(seed);
		q = p;
		if (r[1:0] == 2'b00)
			q.dir = trail_pkg::dir_e'(r[3:2]);
		if (r[5:4] != 2'b00)
			q = advance(q);
		return q;
	endfunction

	function automatic int model_event(trail_pkg::player_e p, trail_pkg::cycle_pos_t now,
		trail_pkg::cycle_pos_t was);
		trail_pkg::tile_e t;
		trail_pkg::collision_t c;
		if (now.pos == was.pos)
			return 0;
		if (now.dir != was.dir)
			t = trail_pkg::TILE_CORNER;
		else if (now.dir == trail_pkg::DIR_UP || now.dir == trail_pkg::DIR_DOWN)
			t = (p == trail_pkg::PLAYER_RED) ? trail_pkg::TILE_R_VERT : trail_pkg::TILE_B_VERT;
		else
			t = (p == trail_pkg::PLAYER_RED) ? trail_pkg::TILE_R_HORIZ : trail_pkg::TILE_B_HORIZ;
		// head lookup sees every earlier trail write
		if (model_map[{now.pos.x, now.pos.y}] != trail_pkg::TILE_EMPTY)
		begin
			c.player = p;
			c.head = now.pos;
			exp_q.push_back(c);
		end
		model_map[{was.pos.x, was.pos.y}] = t;
		touched_q.push_back(was.pos);
		touched_q.push_back(now.pos);
		return 1;
	endfunction

	// one accepted frame, blue first, returns the number of events
	function automatic int model_frame(trail_pkg::game_state_e gs, trail_pkg::cycle_pos_t b,
		trail_pkg::cycle_pos_t r);
		int n;
		n = 0;
		if (gs == trail_pkg::GS_PLAY)
		begin
			n += model_event(trail_pkg::PLAYER_BLUE, b, blue_sv);
			n += model_event(trail_pkg::PLAYER_RED, r, red_sv);
		end
		blue_sv = b;
		red_sv = r;
		return n;
	endfunction

	task automatic check_tile(string sig, trail_pkg::tile_e exp, trail_pkg::tile_e act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s expected %s (%0d) got %s (%0d)", $time, sig,
				exp.name(), exp, act.name(), act);
		end
	endtask

	task automatic check_collision(trail_pkg::collision_t exp, trail_pkg::collision_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: collision expected %0d@(%0d,%0d) got %0d@(%0d,%0d)",
				$time, exp.player, exp.head.x, exp.head.y, act.player, act.head.x, act.head.y);
		end
	endtask

	task automatic check_flag(string sig, logic exp, logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s expected %b got %b", $time, sig, exp, act);
		end
	endtask

	// the detector notices a dropped ack one cycle later and is idle only then
	task automatic step_cycle();
		@(posedge Clk);
		#2;
		det_free = (pending == 0);
		if (det_ack_prev && !trail_grid_top_inst.det_ack)
			pending--;
		det_ack_prev = trail_grid_top_inst.det_ack;
		if (!wr_ack_prev && trail_grid_top_inst.wr_ack)
			wr_done++;
		wr_ack_prev = trail_grid_top_inst.wr_ack;
	endtask

	task automatic issue_tick(int gap);
		int n;
		frame_tick = 1'b1;
		if (det_free)
		begin
			n = model_frame(game_state, blue, red);
			pending += n;
			ev_total += n;
		end
		step_cycle();
		frame_tick = 1'b0;
		repeat (gap - 1) step_cycle();
	endtask

	task automatic wait_done();
		while (wr_done < ev_total || pending != 0)
			step_cycle();
		repeat (10) step_cycle();
	endtask

	task automatic read_cell(trail_pkg::cell_t c, trail_pkg::tile_e exp);
		host_cell = c;
		step_cycle();
		check_tile($sformatf("host_tile(%0d,%0d)", c.x, c.y), exp, host_tile);
	endtask

	task automatic clear_map();
		int n;
		n = 0;
		game_state = trail_pkg::GS_START;
		step_cycle();
		check_flag("clearing", 1'b1, clearing);
		while (clearing)
		begin
			n++;
			step_cycle();
		end
		checks++;
		if (n != trail_pkg::GRID_CELLS)
		begin
			errors++;
			$display("clear sweep lasted %0d cycles instead of %0d", n, trail_pkg::GRID_CELLS);
		end
		foreach (model_map[i])
			model_map[i] = trail_pkg::TILE_EMPTY;
		touched_q.delete();
		repeat (4) step_cycle();
	endtask

	task automatic compare_collisions();
		checks++;
		if (got_q.size() != exp_q.size())
		begin
			errors++;
			$display("wrong number of collision reports at %0t: expected %0d, got %0d",
				$time, exp_q.size(), got_q.size());
		end
		else
			foreach (exp_q[i])
				check_collision(exp_q[i], got_q[i]);
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic report_test(int num, string name);
		$display("test %0d %s: %s, %0d errors", num, name,
			(errors == test_errs) ? "ok" : "failed", errors - test_errs);
		test_errs = errors;
	endtask

	initial
	begin
		seed = 79682;
		{errors, checks, test_errs, pending, ev_total, wr_done} = '0;
		{det_free, det_ack_prev, wr_ack_prev} = 3'b100;
		reset = 1'b1;
		frame_tick = 1'b0;
		game_state = trail_pkg::GS_IDLE;
		blue = '0;
		red = '0;
		host_cell = '0;
		repeat (4) step_cycle();
		reset = 1'b0;

		clear_map();
		read_cell(cell_at(0, 0), trail_pkg::TILE_EMPTY);
		read_cell(cell_at(63, 0), trail_pkg::TILE_EMPTY);
		read_cell(cell_at(0, 63), trail_pkg::TILE_EMPTY);
		read_cell(cell_at(63, 63), trail_pkg::TILE_EMPTY);
		repeat (4) read_cell(cell_at($random(seed) & 63, $random(seed) & 63),
			trail_pkg::TILE_EMPTY);
		report_test(1, "clear");

		// first tick outside play only loads the saved positions
		blue = pos_at(5, 5, trail_pkg::DIR_RIGHT);
		red = pos_at(40, 10, trail_pkg::DIR_DOWN);
		issue_tick(40);
		game_state = trail_pkg::GS_PLAY;
		repeat (5)
		begin
			blue = advance(blue);
			red = advance(red);
			issue_tick(40);
		end
		wait_done();
		for (int i = 0; i < 5; i++)
		begin
			read_cell(cell_at(5 + i, 5), trail_pkg::TILE_B_HORIZ);
			read_cell(cell_at(40, 10 + i), trail_pkg::TILE_R_VERT);
		end
		read_cell(cell_at(10, 5), trail_pkg::TILE_EMPTY);
		read_cell(cell_at(40, 15), trail_pkg::TILE_EMPTY);
		compare_collisions();
		report_test(2, "straight runs");

		blue.dir = trail_pkg::DIR_DOWN;
		blue = advance(blue);
		red.dir = trail_pkg::DIR_LEFT;
		red = advance(red);
		issue_tick(40);
		blue = advance(blue);
		red = advance(red);
		issue_tick(40);
		wait_done();
		read_cell(cell_at(10, 5), trail_pkg::TILE_CORNER);
		read_cell(cell_at(40, 15), trail_pkg::TILE_CORNER);
		read_cell(cell_at(10, 6), trail_pkg::TILE_B_VERT);
		read_cell(cell_at(39, 15), trail_pkg::TILE_R_HORIZ);
		compare_collisions();
		report_test(3, "turns");

		issue_tick(40);
		game_state = trail_pkg::GS_OVER;
		blue = advance(blue);
		red = advance(red);
		issue_tick(40);
		game_state = trail_pkg::GS_IDLE;
		blue = advance(blue);
		red = advance(red);
		issue_tick(40);
		wait_done();
		for (int i = 0; i < 3; i++)
		begin
			read_cell(cell_at(10, 7 + i), trail_pkg::TILE_EMPTY);
			read_cell(cell_at(38 - i, 15), trail_pkg::TILE_EMPTY);
		end
		read_cell(cell_at(10, 6), trail_pkg::TILE_B_VERT);
		compare_collisions();
		report_test(4, "no move or no play");

		// red runs down into blue's row, then back over older trail
		clear_map();
		blue = pos_at(10, 20, trail_pkg::DIR_RIGHT);
		red = pos_at(12, 17, trail_pkg::DIR_DOWN);
		issue_tick(40);
		game_state = trail_pkg::GS_PLAY;
		repeat (3)
		begin
			blue = advance(blue);
			red = advance(red);
			issue_tick(40);
		end
		blue = advance(blue);
		red.dir = trail_pkg::DIR_LEFT;
		red = advance(red);
		issue_tick(40);
		wait_done();
		read_cell(cell_at(12, 20), trail_pkg::TILE_CORNER);
		read_cell(cell_at(11, 20), trail_pkg::TILE_B_HORIZ);
		compare_collisions();
		report_test(5, "collisions");

		clear_map();
		blue = pos_at(20, 30, trail_pkg::DIR_RIGHT);
		red = pos_at(44, 30, trail_pkg::DIR_LEFT);
		issue_tick(40);
		game_state = trail_pkg::GS_PLAY;
		repeat (20)
		begin
			blue = random_move(blue);
			red = random_move(red);
			issue_tick(10);
		end
		wait_done();
		foreach (touched_q[i])
			read_cell(touched_q[i], model_map[{touched_q[i].x, touched_q[i].y}]);
		compare_collisions();
		report_test(6, "back-pressure");

		$display("6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: verilog.f
common/trail_pkg.sv
trail_writer/tile_map.sv
src/trail_detect.sv
src/trail_fifo.sv
trail_writer/trail_writer.sv
src/trail_grid_top.sv
tb/tb_trail_grid.sv
